// ==== source/msx_layout_pkg.sv ====
package msx_layout_pkg;

   typedef logic [7:0]  byte_t;
   typedef logic [5:0]  block_idx_t;   // {slot, subslot, block}
   typedef logic [3:0]  ref_idx_t;
   typedef logic [15:0] page_count_t;  // 16 KB pages
   typedef logic [24:0] fill_len_t;

   typedef enum logic [7:0] {
      MAPPER_UNUSED,
      MAPPER_NONE,
      MAPPER_ASCII8,
      MAPPER_ASCII16,
      MAPPER_KONAMI,
      MAPPER_KONAMI_SCC,
      MAPPER_RAM
   } mapper_t;

   typedef enum logic [7:0] {
      DEVICE_NONE,
      DEVICE_FDC,
      DEVICE_OPL3
   } device_t;

   typedef enum logic [1:0] {MSX1, MSX2, MSX2P} msx_typ_t;

   typedef struct packed {
      mapper_t    mapper;
      device_t    device;
      ref_idx_t   ref_ram;
      logic [1:0] offset_ram;
      logic       cart_num;
   } block_t;

   typedef struct packed {
      logic [26:0] addr;
      page_count_t size;
      logic        ro;
   } lookup_ram_t;

   typedef struct packed {
      logic [3:0] slot_expander_en;
      msx_typ_t   msx_typ;
      byte_t      ram_size;
   } bios_config_t;

   typedef enum logic [2:0] {PAT_DDR3, PAT_FF, PAT_00, PAT_CHECKER_A, PAT_CHECKER_B} fill_pattern_t;

endpackage

// ==== source/upload_format_pkg.sv ====
package upload_format_pkg;

   typedef enum logic [3:0] {
      CFG_SLOT_A,
      CFG_SLOT_B,
      CFG_KBD_LAYOUT,
      CFG_CONFIG,
      CFG_SLOT_INTERNAL
   } record_kind_t;

   typedef enum logic [7:0] {
      ROM_NONE,
      ROM_ROM,
      ROM_RAM
   } data_id_t;

   localparam int          HEADER_BYTES = 16;
   localparam logic [27:0] KBD_SKIP     = 28'h200;   // Keyboard map payload
   localparam logic [23:0] MAGIC        = "MSX";

   localparam int OFS_KIND    = 3;    // Kind in [7:4], slot/subslot in [3:0]
   localparam int OFS_ID      = 4;
   localparam int OFS_SIZE_HI = 5;
   localparam int OFS_SIZE_LO = 6;
   localparam int OFS_DEVICE  = 7;
   localparam int OFS_MAPPER  = 8;
   localparam int OFS_MODE    = 9;
   localparam int OFS_PARAM   = 10;
   localparam int OFS_PATTERN = 11;

   localparam logic [5:0] CONFIG_INDEX = 6'd1;

endpackage

// ==== source/upload_ifs.sv ====
`timescale 1ns/10ps

interface byte_stream_if;
   import msx_layout_pkg::*;

   logic        take;
   byte_t       data;
   logic        valid;
   logic        seek;
   logic [27:0] seek_addr;
   logic [27:0] addr;

   modport server (input take, seek, seek_addr, output data, valid, addr);
   modport client (output take, seek, seek_addr, input data, valid, addr);
endinterface

interface fill_if #(
   parameter int ADDR_W = 27
);
   import msx_layout_pkg::*;

   logic              start;
   logic [ADDR_W-1:0] base;
   fill_len_t         length;
   fill_pattern_t     pattern;
   logic              busy;
   logic [ADDR_W-1:0] end_addr;

   modport initiator (output start, base, length, pattern, input busy, end_addr);
   modport target (input start, base, length, pattern, output busy, end_addr);
endinterface

interface layout_if;
   import msx_layout_pkg::*;

   logic       clear;
   logic       store;
   logic [3:0] slot_sub;
   byte_t      mode;      // 2 bits per block
   byte_t      param;
   mapper_t    mapper;
   device_t    device;
   ref_idx_t   ref_ram;
   logic       cart_num;
   logic       busy;

   modport initiator (
      output clear, store, slot_sub, mode, param, mapper, device, ref_ram, cart_num,
      input  busy
   );
   modport target (
      input  clear, store, slot_sub, mode, param, mapper, device, ref_ram, cart_num,
      output busy
   );
endinterface

// ==== source/ddr3_fetch.sv ====
`timescale 1ns/10ps

module ddr3_fetch (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  busy_sel,
   byte_stream_if.server         hdr,
   byte_stream_if.server         fill,
   output logic [27:0]           ddr3_addr,
   output logic                  ddr3_rd,
   input  msx_layout_pkg::byte_t ddr3_dout,
   input  logic                  ddr3_ready
);

   logic        take;
   logic        seek;
   logic [27:0] seek_addr;
   logic        done;

   assign take      = busy_sel ? fill.take : hdr.take;
   assign seek      = busy_sel ? fill.seek : hdr.seek;
   assign seek_addr = busy_sel ? fill.seek_addr : hdr.seek_addr;
   assign done      = ddr3_rd & ddr3_ready;

   assign hdr.data   = ddr3_dout;
   assign fill.data  = ddr3_dout;
   assign hdr.valid  = done & ~busy_sel;
   assign fill.valid = done & busy_sel;
   assign hdr.addr   = ddr3_addr;
   assign fill.addr  = ddr3_addr;

   always_ff @(posedge clk) begin
      if (reset) begin
         ddr3_rd   <= 1'b0;
         ddr3_addr <= '0;
      end else if (done) begin
         ddr3_rd   <= 1'b0;
         ddr3_addr <= ddr3_addr + 28'd1;
      end else if (!ddr3_rd) begin
         if (seek) ddr3_addr <= seek_addr;  // Only with no read pending
         if (take) ddr3_rd <= 1'b1;
      end
   end

endmodule

// ==== source/ram_filler.sv ====
`timescale 1ns/10ps

module ram_filler #(
   parameter int RAM_ADDR_W = 27
) (
   input  logic                  clk,
   input  logic                  reset,
   fill_if.target                fill,
   byte_stream_if.client         src,
   output logic [RAM_ADDR_W-1:0] ram_addr,
   output msx_layout_pkg::byte_t ram_din,
   output logic                  ram_ce,
   input  logic                  sdram_ready,
   output logic                  sdram_rq
);
   import msx_layout_pkg::*;

   logic          busy;
   fill_len_t     remaining;
   fill_pattern_t pattern;
   logic [8:0]    pos;        // Offset in region modulo 512
   byte_t         src_byte;
   logic          have_byte;
   logic          rd_pend;
   logic          issue;

   assign issue         = busy & have_byte & sdram_ready & ~ram_ce;
   assign src.take      = busy & (pattern == PAT_DDR3) & ~have_byte & ~rd_pend
                          & (remaining != '0);
   assign src.seek      = 1'b0;
   assign src.seek_addr = '0;
   assign fill.busy     = busy;
   assign fill.end_addr = ram_addr;
   assign sdram_rq      = busy;

   always_comb begin
      case (pattern)
         PAT_DDR3:      ram_din = src_byte;
         PAT_00:        ram_din = 8'h00;
         PAT_CHECKER_A: ram_din = (pos[8] == pos[1]) ? 8'hFF : 8'h00;
         PAT_CHECKER_B: ram_din = (pos[8] != pos[0]) ? 8'hFF : 8'h00;
         default:       ram_din = 8'hFF;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         busy      <= 1'b0;
         ram_ce    <= 1'b0;
         have_byte <= 1'b0;
         rd_pend   <= 1'b0;
      end else begin
         ram_ce <= issue;
         if (src.take) rd_pend <= 1'b1;
         if (src.valid) begin
            rd_pend   <= 1'b0;
            have_byte <= 1'b1;
         end
         if (!busy && fill.start) begin
            busy      <= 1'b1;
            have_byte <= fill.pattern != PAT_DDR3;  // Patterns need no source
         end
         if (issue && pattern == PAT_DDR3) have_byte <= 1'b0;
         if (ram_ce && remaining == '0) busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!busy && fill.start) begin
         ram_addr  <= fill.base;
         remaining <= fill.length;
         pattern   <= fill.pattern;
         pos       <= '0;
      end else begin
         if (issue) remaining <= remaining - 1'b1;
         if (ram_ce) begin
            ram_addr <= ram_addr + 1'b1;
            pos      <= pos + 1'b1;
         end
      end
      if (src.valid) src_byte <= src.data;
   end

endmodule

// ==== source/slot_layout_table.sv ====
`timescale 1ns/10ps

module slot_layout_table (
   input  logic                   clk,
   input  logic                   reset,
   layout_if.target               lay,
   output msx_layout_pkg::block_t slot_layout[64]
);
   import msx_layout_pkg::*;

   block_idx_t clr_idx;
   logic       clr_busy;

   // New entry for one block from its 2-bit mode
   function automatic block_t next_entry(block_t cur, block_t src, block_t req,
                                         logic [1:0] m);
      block_t e;
      e = req;
      case (m)
         2'd0: e = cur;
         2'd1: begin
            e.mapper     = src.mapper;
            e.device     = DEVICE_NONE;
            e.ref_ram    = src.ref_ram;
            e.offset_ram = src.offset_ram;
         end
         2'd3: e.mapper = MAPPER_UNUSED;
         default: ;
      endcase
      return e;
   endfunction

   assign lay.busy = clr_busy;

   always_ff @(posedge clk) begin
      if (reset) begin
         clr_busy <= 1'b0;
         clr_idx  <= '0;
      end else if (clr_busy) begin
         clr_idx <= clr_idx + 1'b1;
         if (clr_idx == 6'd63) clr_busy <= 1'b0;
      end else if (lay.clear) begin
         clr_busy <= 1'b1;
         clr_idx  <= '0;
      end
   end

   always_ff @(posedge clk) begin
      block_t     req;
      block_idx_t idx;
      if (clr_busy) begin
         slot_layout[clr_idx] <= '{mapper: MAPPER_UNUSED, device: DEVICE_NONE, default: '0};
      end else if (lay.store) begin
         // Copies see the table before this store
         for (int b = 0; b < 4; b++) begin
            idx = {lay.slot_sub, 2'(b)};
            req = '{mapper: lay.mapper, device: lay.device, ref_ram: lay.ref_ram,
                    offset_ram: lay.param[2*b +: 2], cart_num: lay.cart_num};
            slot_layout[idx] <= next_entry(slot_layout[idx],
                                           slot_layout[{lay.slot_sub, lay.param[2*b +: 2]}],
                                           req, lay.mode[2*b +: 2]);
         end
      end
   end

endmodule

// ==== source/record_sequencer.sv ====
`timescale 1ns/10ps

module record_sequencer #(
   parameter int RAM_ADDR_W = 27
) (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         ioctl_download,
   input  logic [15:0]                  ioctl_index,
   input  logic [26:0]                  ioctl_addr,
   output logic                         reset_rq,
   output logic                         ddr3_request,
   byte_stream_if.client                hdr,
   fill_if.initiator                    fill,
   layout_if.initiator                  lay,
   output msx_layout_pkg::lookup_ram_t  lookup_ram[16],
   output msx_layout_pkg::bios_config_t bios_config
);
   import msx_layout_pkg::*;
   import upload_format_pkg::*;

   typedef enum logic [2:0] {IDLE, CLEAN, READ_HEADER, CHECK, FILL, STORE, DONE} state_t;

   state_t                state;
   logic                  dl_last;
   logic                  dl_end;
   logic                  load;
   logic [26:0]           image_size;
   byte_t                 conf[HEADER_BYTES];
   logic [3:0]            hdr_cnt;
   logic                  rd_pend;
   logic                  fill_sent;
   ref_idx_t              ref_ram;
   logic [RAM_ADDR_W-1:0] ram_base;   // Next free SDRAM address
   logic                  magic_ok;
   logic                  at_end;
   record_kind_t          kind;
   data_id_t              data_id;
   page_count_t           pages;

   assign dl_end   = dl_last && !ioctl_download && ioctl_index[5:0] == CONFIG_INDEX;
   assign magic_ok = {conf[0], conf[1], conf[2]} == MAGIC;
   assign kind     = record_kind_t'(conf[OFS_KIND][7:4]);
   assign data_id  = data_id_t'(conf[OFS_ID]);
   assign pages    = {conf[OFS_SIZE_HI], conf[OFS_SIZE_LO]};
   assign at_end   = hdr_cnt == 4'd0 && hdr.addr >= 28'(image_size);

   assign reset_rq     = state != IDLE && state != DONE;
   assign ddr3_request = state != IDLE;

   assign hdr.take      = state == READ_HEADER && !rd_pend && !at_end;
   assign hdr.seek      = load || (state == CHECK && magic_ok && kind == CFG_KBD_LAYOUT);
   assign hdr.seek_addr = load ? 28'd0 : hdr.addr + KBD_SKIP;

   assign fill.start   = state == FILL && !fill_sent && pages != '0;
   assign fill.base    = ram_base;
   assign fill.length  = fill_len_t'({pages[10:0], 14'h0});
   assign fill.pattern = data_id == ROM_RAM ? fill_pattern_t'(conf[OFS_PATTERN][2:0]) : PAT_DDR3;

   assign lay.clear    = load;
   assign lay.store    = state == STORE;
   assign lay.slot_sub = conf[OFS_KIND][3:0];
   assign lay.mode     = conf[OFS_MODE];
   assign lay.param    = conf[OFS_PARAM];
   assign lay.mapper   = mapper_t'(conf[OFS_MAPPER]);
   assign lay.device   = device_t'(conf[OFS_DEVICE]);
   assign lay.ref_ram  = ref_ram;
   assign lay.cart_num = 1'b0;          // Internal slots only

   always_ff @(posedge clk) begin
      if (reset) begin
         dl_last <= 1'b0;
         load    <= 1'b0;
      end else begin
         dl_last <= ioctl_download;
         load    <= dl_end;
      end
      if (dl_end) image_size <= ioctl_addr;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= IDLE;
         hdr_cnt     <= '0;
         rd_pend     <= 1'b0;
         fill_sent   <= 1'b0;
         ref_ram     <= '0;
         bios_config <= '0;
      end else if (load) begin
         state                <= CLEAN;
         hdr_cnt              <= '0;
         rd_pend              <= 1'b0;
         fill_sent            <= 1'b0;
         ref_ram              <= '0;
         ram_base             <= '0;
         bios_config.ram_size <= 8'h00;
      end else begin
         case (state)
            CLEAN: if (!lay.busy) state <= READ_HEADER;
            READ_HEADER: begin
               if (hdr.valid) begin
                  conf[hdr_cnt] <= hdr.data;
                  rd_pend       <= 1'b0;
                  hdr_cnt       <= hdr_cnt + 1'b1;
                  if (hdr_cnt == 4'(HEADER_BYTES - 1)) state <= CHECK;
               end else if (at_end) begin
                  state <= DONE;          // End of image
               end else if (hdr.take) begin
                  rd_pend <= 1'b1;
               end
            end
            CHECK: begin
               state <= DONE;
               if (magic_ok) begin
                  state <= READ_HEADER;
                  case (kind)
                     CFG_CONFIG: begin
                        bios_config.slot_expander_en <= conf[OFS_ID][3:0];
                        bios_config.msx_typ          <= msx_typ_t'(conf[OFS_ID][5:4]);
                     end
                     CFG_SLOT_INTERNAL: begin
                        state <= FILL;
                        if (data_id == ROM_RAM && conf[OFS_SIZE_LO] > bios_config.ram_size)
                           bios_config.ram_size <= conf[OFS_SIZE_LO];
                     end
                     default: ;               // Keyboard skip via seek
                  endcase
               end
            end
            FILL: begin
               if (fill.start) begin
                  fill_sent           <= 1'b1;
                  lookup_ram[ref_ram] <= '{addr: 27'(ram_base), size: pages,
                                           ro: data_id != ROM_RAM};
               end else if (pages == '0) begin
                  state <= STORE;
               end else if (!fill.busy) begin
                  fill_sent <= 1'b0;
                  ram_base  <= fill.end_addr;
                  state     <= STORE;
               end
            end
            STORE: begin
               ref_ram <= ref_ram + ref_idx_t'(pages != '0);
               state   <= READ_HEADER;
            end
            DONE: state <= IDLE;
            default: ;
         endcase
      end
   end

endmodule

// ==== source/memory_upload.sv ====
`timescale 1ns/10ps

module memory_upload #(
   parameter int RAM_ADDR_W = 27
) (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         ioctl_download,
   input  logic [15:0]                  ioctl_index,
   input  logic [26:0]                  ioctl_addr,
   output logic [27:0]                  ddr3_addr,
   output logic                         ddr3_rd,
   input  msx_layout_pkg::byte_t        ddr3_dout,
   input  logic                         ddr3_ready,
   output logic                         ddr3_request,
   output logic [RAM_ADDR_W-1:0]        ram_addr,
   output msx_layout_pkg::byte_t        ram_din,
   output logic                         ram_ce,
   input  logic                         sdram_ready,
   output logic                         sdram_rq,
   output logic                         reset_rq,
   output msx_layout_pkg::block_t       slot_layout[64],
   output msx_layout_pkg::lookup_ram_t  lookup_ram[16],
   output msx_layout_pkg::bios_config_t bios_config
);

   byte_stream_if                 hdr_stream ();
   byte_stream_if                 fill_stream ();
   fill_if #(.ADDR_W(RAM_ADDR_W)) fill_bus ();
   layout_if                      lay_bus ();

   ddr3_fetch ddr3_fetch_inst (
      .clk        (clk),
      .reset      (reset),
      .busy_sel   (fill_bus.busy),
      .hdr        (hdr_stream.server),
      .fill       (fill_stream.server),
      .ddr3_addr  (ddr3_addr),
      .ddr3_rd    (ddr3_rd),
      .ddr3_dout  (ddr3_dout),
      .ddr3_ready (ddr3_ready)
   );

   ram_filler #(.RAM_ADDR_W(RAM_ADDR_W)) ram_filler_inst (
      .clk         (clk),
      .reset       (reset),
      .fill        (fill_bus.target),
      .src         (fill_stream.client),
      .ram_addr    (ram_addr),
      .ram_din     (ram_din),
      .ram_ce      (ram_ce),
      .sdram_ready (sdram_ready),
      .sdram_rq    (sdram_rq)
   );

   slot_layout_table slot_layout_table_inst (
      .clk         (clk),
      .reset       (reset),
      .lay         (lay_bus.target),
      .slot_layout (slot_layout)
   );

   record_sequencer #(.RAM_ADDR_W(RAM_ADDR_W)) record_sequencer_inst (
      .clk            (clk),
      .reset          (reset),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ioctl_addr     (ioctl_addr),
      .reset_rq       (reset_rq),
      .ddr3_request   (ddr3_request),
      .hdr            (hdr_stream.client),
      .fill           (fill_bus.initiator),
      .lay            (lay_bus.initiator),
      .lookup_ram     (lookup_ram),
      .bios_config    (bios_config)
   );

endmodule

// ==== dv/memory_upload_tb.sv ====
`timescale 1ns/10ps

module memory_upload_tb;
   import msx_layout_pkg::*;

   localparam int DDR3_BYTES  = 'h8000;
   localparam int SDRAM_BYTES = 'h14000;
   localparam int WALK_LIMIT  = 2000000;   // Cycles for the whole record walk

   logic         clk = 1'b0;
   logic         reset = 1'b1;
   logic         ioctl_download = 1'b0;
   logic [15:0]  ioctl_index = '0;
   logic [26:0]  ioctl_addr = '0;
   logic [27:0]  ddr3_addr;
   logic         ddr3_rd;
   byte_t        ddr3_dout = '0;
   logic         ddr3_ready = 1'b0;
   logic         ddr3_request;
   logic [26:0]  ram_addr;
   byte_t        ram_din;
   logic         ram_ce;
   logic         sdram_ready = 1'b0;
   logic         sdram_rq;
   logic         reset_rq;
   block_t       slot_layout[64];
   lookup_ram_t  lookup_ram[16];
   bios_config_t bios_config;

   byte_t        ddr3_mem[DDR3_BYTES];
   byte_t        sdram_mem[SDRAM_BYTES];
   logic [31:0]  rnd = 32'd8121;
   int           errors = 0;
   int           checks = 0;
   int           image_size = 0;
   block_t       exp_layout[64];
   logic         layout_listed[64];
   lookup_ram_t  exp_lookup[16];
   logic         lookup_listed[16];
   lookup_ram_t  lookup_before[16];
   bios_config_t exp_bios;
   int           ram_chk_addr[$];
   int           ram_chk_val[$];

   memory_upload #(.RAM_ADDR_W(27)) memory_upload_inst (.*);

   always #5 clk = ~clk;

   function automatic logic [31:0] lcg_next(logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // Background bytes, different for every address
   function automatic byte_t ddr3_pattern(int a);
      return byte_t'(a) ^ byte_t'(a >> 8) ^ 8'hC3;
   endfunction

   function automatic byte_t sdram_pattern(int a);
      return byte_t'(a) ^ byte_t'(a >> 8) ^ byte_t'(a >> 16) ^ 8'h5A;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("[ERROR] %s got %h expected %h", name, got, expected);
      end
   endtask

   task automatic load_golden();
      int               fd;
      int               code;
      int               f0, f1, f2, f3, f4, f5;
      logic [63:0]      tag;
      logic [8*128-1:0] rest;
      for (int i = 0; i < DDR3_BYTES; i++) ddr3_mem[i] = ddr3_pattern(i);
      for (int i = 0; i < SDRAM_BYTES; i++) sdram_mem[i] = sdram_pattern(i);
      for (int i = 0; i < 64; i++) begin
         exp_layout[i]    = '{mapper: MAPPER_UNUSED, device: DEVICE_NONE, default: '0};
         layout_listed[i] = 1'b0;
      end
      for (int i = 0; i < 16; i++) lookup_listed[i] = 1'b0;
      fd = $fopen("dv/upload_golden.txt", "r");
      if (fd == 0) begin
         $display("Could not open the golden file dv/upload_golden.txt");
         errors++;
         return;
      end
      while ($fscanf(fd, "%s", tag) == 1) begin
         case (tag)
            "#": code = $fgets(rest, fd);
            "D": begin
               code = $fscanf(fd, "%h", f0);
               for (int i = 0; i < 16; i++) begin
                  code = $fscanf(fd, "%h", f1);
                  ddr3_mem[f0 + i] = byte_t'(f1);
               end
            end
            "S": code = $fscanf(fd, "%h", image_size);
            "L": begin
               code = $fscanf(fd, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
               exp_layout[f0]    = {8'(f1), 8'(f2), 4'(f3), 2'(f4), 1'(f5)};
               layout_listed[f0] = 1'b1;
            end
            "K": begin
               code = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
               exp_lookup[f0]    = {27'(f1), 16'(f2), 1'(f3)};
               lookup_listed[f0] = 1'b1;
            end
            "B": begin
               code     = $fscanf(fd, "%h %h %h", f0, f1, f2);
               exp_bios = {4'(f0), 2'(f1), 8'(f2)};
            end
            "R": begin
               code = $fscanf(fd, "%h %h", f0, f1);
               ram_chk_addr.push_back(f0);
               ram_chk_val.push_back(f1);
            end
            default: begin
               $display("Unknown line type in the golden file");
               errors++;
               code = $fgets(rest, fd);
            end
         endcase
      end
      $fclose(fd);
   endtask

   task automatic wait_reset_rq(input logic level, input int limit);
      int n;
      n = 0;
      while (reset_rq !== level && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (reset_rq !== level) begin
         $display("Timeout while waiting for reset_rq to become %0d", level);
         errors++;
      end
   endtask

   task automatic check_results();
      lookup_ram_t exp_entry;
      for (int i = 0; i < 64; i++) begin
         check_value($sformatf("slot_layout[%0d].mapper", i), slot_layout[i].mapper,
                     exp_layout[i].mapper);
         check_value($sformatf("slot_layout[%0d].device", i), slot_layout[i].device,
                     exp_layout[i].device);
         if (layout_listed[i]) begin
            check_value($sformatf("slot_layout[%0d].ref_ram", i), slot_layout[i].ref_ram,
                        exp_layout[i].ref_ram);
            check_value($sformatf("slot_layout[%0d].offset_ram", i),
                        slot_layout[i].offset_ram, exp_layout[i].offset_ram);
            check_value($sformatf("slot_layout[%0d].cart_num", i), slot_layout[i].cart_num,
                        exp_layout[i].cart_num);
         end
      end
      for (int i = 0; i < 16; i++) begin
         // Unwritten entries keep their value from before the download
         exp_entry = lookup_listed[i] ? exp_lookup[i] : lookup_before[i];
         check_value($sformatf("lookup_ram[%0d].addr", i), lookup_ram[i].addr,
                     exp_entry.addr);
         check_value($sformatf("lookup_ram[%0d].size", i), lookup_ram[i].size,
                     exp_entry.size);
         check_value($sformatf("lookup_ram[%0d].ro", i), lookup_ram[i].ro,
                     exp_entry.ro);
      end
      check_value("bios_config.slot_expander_en", bios_config.slot_expander_en,
                  exp_bios.slot_expander_en);
      check_value("bios_config.msx_typ", bios_config.msx_typ, exp_bios.msx_typ);
      check_value("bios_config.ram_size", bios_config.ram_size, exp_bios.ram_size);
      foreach (ram_chk_addr[i])
         check_value($sformatf("sdram[%05h]", ram_chk_addr[i]), sdram_mem[ram_chk_addr[i]],
                     ram_chk_val[i]);
   endtask

   // DDR3 and SDRAM models with random ready
   always @(posedge clk) begin
      rnd = lcg_next(rnd);
      if (ddr3_rd && !ddr3_ready) begin
         if (ddr3_addr < DDR3_BYTES) begin
            ddr3_dout <= ddr3_mem[ddr3_addr];
         end else begin
            $display("DDR3 read outside the model at address %h", ddr3_addr);
            errors++;
         end
         ddr3_ready <= rnd[31:30] != 2'b00;
      end else begin
         ddr3_ready <= 1'b0;   // Read completes on this edge
      end
      rnd = lcg_next(rnd);
      sdram_ready <= rnd[31:30] != 2'b00;
      if (ram_ce) begin
         if (ram_addr < SDRAM_BYTES) begin
            sdram_mem[ram_addr] = ram_din;
         end else begin
            $display("SDRAM write outside the model at address %h", ram_addr);
            errors++;
         end
      end
   end

   initial begin
      int n;
      load_golden();
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_value("reset_rq", reset_rq, 0);
      check_value("ddr3_rd", ddr3_rd, 0);
      check_value("ddr3_request", ddr3_request, 0);
      check_value("ram_ce", ram_ce, 0);
      check_value("sdram_rq", sdram_rq, 0);
      foreach (lookup_before[i])
         lookup_before[i] = lookup_ram[i];

      @(posedge clk);
      ioctl_index    <= 16'd1;
      ioctl_addr     <= 27'(image_size);
      ioctl_download <= 1'b1;
      repeat (3) @(posedge clk);
      ioctl_download <= 1'b0;   // End of download starts the walk

      wait_reset_rq(1'b1, 20);
      wait_reset_rq(1'b0, WALK_LIMIT);
      n = 0;
      while (ddr3_request !== 1'b0 && n < 20) begin
         @(negedge clk);
         n++;
      end
      if (ddr3_request !== 1'b0) begin
         $display("Timeout while waiting for ddr3_request to drop");
         errors++;
      end
      repeat (2) @(negedge clk);
      check_results();

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

// ==== dv/upload_golden.txt ====
# D: DDR3 address, 16 header bytes. S: image size. L: block mapper device ref_ram offset cart
# K: lookup index addr pages ro. B: expander msx_typ ram_size. R: SDRAM address, expected byte
# CONFIG, expanders a, MSX2P
D 0000 4d 53 58 30 2a 00 00 00 00 00 00 00 00 00 00 00
# ROM into slot 0 sub 1, one page copied from 0x0020
D 0010 4d 53 58 41 01 00 01 01 02 aa e4 00 00 00 00 00
# Keyboard layout, payload 0x4030 to 0x422f skipped
D 4020 4d 53 58 20 00 00 00 00 00 00 00 00 00 00 00 00
# RAM checker A, two pages, slot 1 sub 2
D 4230 4d 53 58 46 02 00 02 02 06 aa e4 03 00 00 00 00
# RAM FF, one page, modes 0 1 2 3 in the same subslot
D 4240 4d 53 58 46 02 00 01 01 05 e4 9c 01 00 00 00 00
# Bad magic, then a record that must not be applied
D 4250 4d 53 59 4a 02 00 01 01 06 aa e4 02 00 00 00 00
D 4260 4d 53 58 4b 02 00 01 00 06 aa e4 02 00 00 00 00
S 4270
L 04 02 01 0 0 0
L 05 02 01 0 1 0
L 06 02 01 0 2 0
L 07 02 01 0 3 0
L 18 06 02 1 0 0
L 19 06 00 1 3 0
L 1a 05 01 2 1 0
L 1b 00 01 2 2 0
K 0 0000000 0001 1
K 1 0004000 0002 0
K 2 000c000 0001 0
B a 2 02
R 00000 e3
R 01234 85
R 03fff 9c
R 04000 ff
R 04002 00
R 04101 00
R 04103 ff
R 0bfff ff
R 0c000 ff
R 0ffff ff
R 10000 5b
R 10005 5e

// ==== memory_upload.f ====
source/msx_layout_pkg.sv
source/upload_format_pkg.sv
source/upload_ifs.sv
source/ddr3_fetch.sv
source/ram_filler.sv
source/slot_layout_table.sv
source/record_sequencer.sv
source/memory_upload.sv
dv/memory_upload_tb.sv

// ==== Makefile ====
LOG = sim.log

sim:
	verilator --binary --timing -Wno-fatal --top-module memory_upload_tb \
		-f memory_upload.f -o memory_upload_sim
	./obj_dir/memory_upload_sim | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
